// ==== fetch.f ====
+incdir+src
src/fetch_pkg.sv
src/fetch_push_if.sv
src/fetch_ctrl.sv
src/fetch_buf.sv
src/instr_issue.sv
src/fetch_top.sv
tb/imem_model.sv
tb/fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fetch_tb -f fetch.f -o fetch_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// ==== src/fetch_buf.sv ====
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_buf
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  fetch_pkg::pc_t      i_start_pc,
    input  logic                i_pop,
    fetch_push_if.buffer        push,
    output fetch_pkg::half_t    o_data_lo,
    output fetch_pkg::half_t    o_data_hi,
    output fetch_pkg::pc_t      o_pc,
    output logic                o_compressed,
    output logic                o_empty,
    output logic                o_full
);

    import fetch_pkg::*;

    localparam int QSize   = 1 << `FETCH_DEPTH_BITS;
    localparam int CntBits = `FETCH_DEPTH_BITS + 1;

    typedef logic [CntBits-1:0] cnt_t;

    half_t  data [QSize];
    half_t  data_next [QSize];
    cnt_t   head;
    cnt_t   head_pop;
    cnt_t   pop_cnt;
    cnt_t   push_cnt;
    pc_t    pc;
    logic   is_comp;
    logic   pop_single;
    logic   pop_double;

    assign is_comp    = (data[0][1:0] != 2'b11);
    assign pop_single = i_pop && is_comp;
    assign pop_double = i_pop && !is_comp;

    assign pop_cnt  = pop_double ? cnt_t'(2) : (pop_single ? cnt_t'(1) : cnt_t'(0));
    assign push_cnt = push.push_double ? cnt_t'(2) : (push.push_single ? cnt_t'(1) : cnt_t'(0));

    // Pushes land at the head as it stands after this cycle's pop
    assign head_pop = head - pop_cnt;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            head <= '0;
        else
            head <= head_pop + push_cnt;
    end

    for (genvar i = 0; i < QSize; i++)
    begin : g_slot
        logic   wr_hi;
        logic   wr_lo;
        half_t  shift1;
        half_t  shift2;

        assign wr_hi = (push.push_single && (head_pop == cnt_t'(i))) ||
                       (push.push_double && ((head_pop + cnt_t'(1)) == cnt_t'(i)));
        assign wr_lo = push.push_double && (head_pop == cnt_t'(i));

        if (i + 1 < QSize)
        begin : g_s1
            assign shift1 = data[i+1];
        end
        else
        begin : g_s1_end
            assign shift1 = '0;
        end

        if (i + 2 < QSize)
        begin : g_s2
            assign shift2 = data[i+2];
        end
        else
        begin : g_s2_end
            assign shift2 = '0;
        end

        assign data_next[i] = wr_hi      ? push.data_hi :
                              wr_lo      ? push.data_lo :
                              pop_single ? shift1 :
                              pop_double ? shift2 :
                              data[i];
    end

    always_ff @(posedge i_clk)
    begin
        data <= data_next;
    end

    // The pc follows the head instruction
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc <= i_start_pc;
        else if (pop_single)
            pc <= pc + pc_t'(1);
        else if (pop_double)
            pc <= pc + pc_t'(2);
    end

    assign o_data_lo    = data[0];
    assign o_data_hi    = data[1];
    assign o_pc         = pc;
    assign o_compressed = is_comp;
    assign o_empty      = (head == '0) || (!is_comp && (head == cnt_t'(1)));
    assign o_full       = (head >= cnt_t'(QSize - 2));  // Leaves room for a double push

endmodule

// ==== src/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Instruction address width in bits; the pc drops bit 0 and counts halfwords
`define FETCH_PC_BITS 16

// Log2 of the fetch buffer depth in halfwords
`define FETCH_DEPTH_BITS 3

`endif

// ==== src/fetch_ctrl.sv ====
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_ctrl
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  fetch_pkg::pc_t              i_start_pc,
    input  fetch_pkg::word_t            i_imem_rdata,
    input  logic                        i_imem_valid,
    input  logic                        i_full,
    output logic                        o_imem_req,
    output logic [`FETCH_PC_BITS-3:0]   o_imem_addr,
    fetch_push_if.ctrl                  push
);

    logic [`FETCH_PC_BITS-3:0]  word_addr;
    logic                       outstanding;
    logic                       first_odd;
    logic                       req;
    logic                       issue;
    logic                       resp;

    // Only one read may be in flight, and it must fit once it returns
    assign issue = !outstanding && !i_full;
    assign resp  = outstanding && i_imem_valid;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            word_addr   <= i_start_pc[`FETCH_PC_BITS-2:1];
            outstanding <= 1'b0;
            first_odd   <= i_start_pc[0];   // Start in the upper half of a word
            req         <= 1'b0;
        end
        else
        begin
            req <= 1'b0;
            if (issue)
            begin
                req         <= 1'b1;
                outstanding <= 1'b1;
            end
            if (resp)
            begin
                outstanding <= 1'b0;
                first_odd   <= 1'b0;
                word_addr   <= word_addr + 1'b1;
            end
        end
    end

    // The response goes straight into the buffer in the cycle it arrives
    assign push.data_lo     = i_imem_rdata[15:0];
    assign push.data_hi     = i_imem_rdata[31:16];
    assign push.push_single = resp && first_odd;
    assign push.push_double = resp && !first_odd;

    assign o_imem_req  = req;
    assign o_imem_addr = word_addr;

endmodule

// ==== src/fetch_pkg.sv ====
`include "fetch_config.svh"

package fetch_pkg;

    typedef logic [`FETCH_PC_BITS-2:0] pc_t;    // Halfword address
    typedef logic [15:0] half_t;                // One instruction parcel
    typedef logic [31:0] word_t;                // Memory word or full instruction

    // Compressed quadrants first, then the 32-bit major opcode groups
    typedef enum logic [3:0]
    {
        C_Q0,
        C_Q1,
        C_Q2,
        LOAD,
        STORE,
        BRANCH,
        JAL,
        JALR,
        OP,
        OP_IMM,
        LUI_AUIPC,
        SYSTEM,
        OTHER
    } instr_class_e;

endpackage

// ==== src/fetch_push_if.sv ====
`timescale 1ns/1ps

interface fetch_push_if;

    import fetch_pkg::*;

    half_t  data_lo;        // Written at the head on a double push
    half_t  data_hi;        // Written above data_lo, or alone on a single push
    logic   push_single;
    logic   push_double;

    modport ctrl
    (
        output data_lo,
        output data_hi,
        output push_single,
        output push_double
    );

    modport buffer
    (
        input  data_lo,
        input  data_hi,
        input  push_single,
        input  push_double
    );

endinterface

// ==== src/fetch_top.sv ====
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_top
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  fetch_pkg::pc_t              i_start_pc,
    input  fetch_pkg::word_t            i_imem_rdata,
    input  logic                        i_imem_valid,
    input  logic                        i_instr_ready,
    output logic                        o_imem_req,
    output logic [`FETCH_PC_BITS-3:0]   o_imem_addr,
    output fetch_pkg::word_t            o_instr,
    output fetch_pkg::pc_t              o_instr_pc,
    output fetch_pkg::instr_class_e     o_instr_class,
    output logic                        o_instr_valid
);

    import fetch_pkg::*;

    half_t  buf_data_lo;
    half_t  buf_data_hi;
    pc_t    buf_pc;
    logic   buf_compressed;
    logic   buf_empty;
    logic   buf_full;
    logic   pop;

    fetch_push_if push_bus ();

    fetch_ctrl u_ctrl
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_start_pc     (i_start_pc),
        .i_imem_rdata   (i_imem_rdata),
        .i_imem_valid   (i_imem_valid),
        .i_full         (buf_full),
        .o_imem_req     (o_imem_req),
        .o_imem_addr    (o_imem_addr),
        .push           (push_bus.ctrl)
    );

    fetch_buf u_buf
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_start_pc     (i_start_pc),
        .i_pop          (pop),
        .push           (push_bus.buffer),
        .o_data_lo      (buf_data_lo),
        .o_data_hi      (buf_data_hi),
        .o_pc           (buf_pc),
        .o_compressed   (buf_compressed),
        .o_empty        (buf_empty),
        .o_full         (buf_full)
    );

    instr_issue u_issue
    (
        .i_data_lo      (buf_data_lo),
        .i_data_hi      (buf_data_hi),
        .i_pc           (buf_pc),
        .i_compressed   (buf_compressed),
        .i_empty        (buf_empty),
        .i_instr_ready  (i_instr_ready),
        .o_pop          (pop),
        .o_instr        (o_instr),
        .o_instr_pc     (o_instr_pc),
        .o_instr_class  (o_instr_class),
        .o_instr_valid  (o_instr_valid)
    );

endmodule

// ==== src/instr_issue.sv ====
`timescale 1ns/1ps

module instr_issue
(
    input  fetch_pkg::half_t        i_data_lo,
    input  fetch_pkg::half_t        i_data_hi,
    input  fetch_pkg::pc_t          i_pc,
    input  logic                    i_compressed,
    input  logic                    i_empty,
    input  logic                    i_instr_ready,
    output logic                    o_pop,
    output fetch_pkg::word_t        o_instr,
    output fetch_pkg::pc_t          o_instr_pc,
    output fetch_pkg::instr_class_e o_instr_class,
    output logic                    o_instr_valid
);

    import fetch_pkg::*;

    logic           valid;
    instr_class_e   cls;

    assign valid = !i_empty;

    always_comb
    begin
        if (i_compressed)
        begin
            case (i_data_lo[1:0])
                2'b00:   cls = C_Q0;
                2'b01:   cls = C_Q1;
                2'b10:   cls = C_Q2;
                default: cls = OTHER;
            endcase
        end
        else
        begin
            case (i_data_lo[6:2])   // Major opcode
                5'b00000: cls = LOAD;
                5'b01000: cls = STORE;
                5'b11000: cls = BRANCH;
                5'b11011: cls = JAL;
                5'b11001: cls = JALR;
                5'b01100: cls = OP;
                5'b00100: cls = OP_IMM;
                5'b01101,
                5'b00101: cls = LUI_AUIPC;
                5'b11100: cls = SYSTEM;
                default:  cls = OTHER;
            endcase
        end
    end

    assign o_instr       = i_compressed ? {16'h0000, i_data_lo} : {i_data_hi, i_data_lo};
    assign o_instr_pc    = i_pc;
    assign o_instr_class = cls;
    assign o_instr_valid = valid;
    assign o_pop         = valid && i_instr_ready;  // Consumer takes the head this cycle

endmodule

// ==== tb/fetch_tb.sv ====
`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_tb;

    import fetch_pkg::*;

    localparam int MemHalves    = 1 << (`FETCH_PC_BITS - 1);
    localparam int ValidTimeout = 64;

    typedef struct packed
    {
        word_t          word;
        logic [5:0]     len;    // 16 or 32
        instr_class_e   cls;
        logic [7:0]     stall;  // Cycles with ready held low
    } row_t;

    logic                       i_clk;
    logic                       i_reset_n;
    pc_t                        i_start_pc;
    word_t                      i_imem_rdata;
    logic                       i_imem_valid;
    logic                       i_instr_ready;
    logic                       o_imem_req;
    logic [`FETCH_PC_BITS-3:0]  o_imem_addr;
    word_t                      o_instr;
    pc_t                        o_instr_pc;
    instr_class_e               o_instr_class;
    logic                       o_instr_valid;

    logic [`FETCH_PC_BITS-3:0]  exp_addr;

    row_t   rows [$];

    fetch_top UUT
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_start_pc     (i_start_pc),
        .i_imem_rdata   (i_imem_rdata),
        .i_imem_valid   (i_imem_valid),
        .i_instr_ready  (i_instr_ready),
        .o_imem_req     (o_imem_req),
        .o_imem_addr    (o_imem_addr),
        .o_instr        (o_instr),
        .o_instr_pc     (o_instr_pc),
        .o_instr_class  (o_instr_class),
        .o_instr_valid  (o_instr_valid)
    );

    imem_model u_imem
    (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_req      (o_imem_req),
        .i_addr     (o_imem_addr),
        .o_rdata    (i_imem_rdata),
        .o_valid    (i_imem_valid)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic stop_on_error();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic word_check(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s expected %08h, got %08h", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic pc_check(input string name, input pc_t got, input pc_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s expected %04h, got %04h", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic addr_check(input string name, input logic [`FETCH_PC_BITS-3:0] got,
                              input logic [`FETCH_PC_BITS-3:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s expected %04h, got %04h", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic class_check(input string name, input instr_class_e got,
                               input instr_class_e exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s expected %s, got %s (%0d)",
                     $time, name, exp.name(), got.name(), got);
            stop_on_error();
        end
    endtask

    task automatic bit_check(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    // Fetch is sequential, so each request reads the word after the previous one
    always @(negedge i_clk)
    begin
        if (!i_reset_n)
            exp_addr = i_start_pc[`FETCH_PC_BITS-2:1];
        else if (o_imem_req)
        begin
            addr_check("o_imem_addr", o_imem_addr, exp_addr);
            exp_addr = exp_addr + 1'b1;
        end
    end

    task automatic add_row(input word_t word, input int len, input instr_class_e cls,
                           input int stall);
        row_t r;
        r.word  = word;
        r.len   = 6'(len);
        r.cls   = cls;
        r.stall = 8'(stall);
        rows.push_back(r);
    endtask

    // Quadrant classes for 16-bit rows, opcode[6:2] classes for 32-bit rows
    task automatic build_table();
        add_row(32'h00A00093, 32, OP_IMM,    0);
        add_row(32'h00002103, 32, LOAD,      0);
        add_row(32'h002081B3, 32, OP,        1);
        add_row(32'h00312023, 32, STORE,     0);
        add_row(32'h12345237, 32, LUI_AUIPC, 3);
        add_row(32'h00004501, 16, C_Q1,      0);
        add_row(32'h00000517, 32, LUI_AUIPC, 0);   // Straddles a word
        add_row(32'h00000808, 16, C_Q0,      2);
        add_row(32'h00008082, 16, C_Q2,      0);
        add_row(32'h00208663, 32, BRANCH,    0);
        add_row(32'h008000EF, 32, JAL,       24);  // Long stall lets the buffer fill
        add_row(32'h00004585, 16, C_Q1,      0);
        add_row(32'h000080E7, 32, JALR,      0);
        add_row(32'h00000073, 32, SYSTEM,    5);
        add_row(32'h00004502, 16, C_Q2,      0);
        add_row(32'h0000000F, 32, OTHER,     0);
        add_row(32'h40B50533, 32, OP,        0);
    endtask

    task automatic load_memory(input pc_t start);
        pc_t pc;
        for (int a = 0; a < MemHalves; a++)
            u_imem.mem[a] = half_t'(a) ^ 16'hC3A5;
        pc = start;
        foreach (rows[n])
        begin
            u_imem.mem[pc] = rows[n].word[15:0];
            if (rows[n].len == 6'd32)
                u_imem.mem[pc + pc_t'(1)] = rows[n].word[31:16];
            pc = pc + pc_t'(rows[n].len / 16);
        end
    endtask

    task automatic apply_reset(input pc_t start);
        @(negedge i_clk);
        i_reset_n     = 1'b0;
        i_start_pc    = start;
        i_instr_ready = 1'b0;
        load_memory(start);
        for (int c = 0; c < 8; c++)
        begin
            @(negedge i_clk);
            bit_check("o_imem_req", o_imem_req, 1'b0);
            bit_check("o_instr_valid", o_instr_valid, 1'b0);
        end
        i_reset_n = 1'b1;
        @(negedge i_clk);
        bit_check("o_instr_valid", o_instr_valid, 1'b0);
    endtask

    task automatic wait_for_valid(input int row);
        int cycles;
        cycles = 0;
        while (o_instr_valid !== 1'b1)
        begin
            if (cycles >= ValidTimeout)
            begin
                $display("Timeout at %0t ns: no instruction became valid for row %0d",
                         $time, row);
                stop_on_error();
            end
            @(negedge i_clk);
            cycles++;
        end
    endtask

    task automatic run_table(input pc_t start);
        pc_t    exp_pc;
        word_t  exp_instr;
        row_t   r;
        apply_reset(start);
        exp_pc = start;
        for (int n = 0; n < rows.size(); n++)
        begin
            r = rows[n];
            exp_instr = r.word;
            i_instr_ready = (r.stall == 8'd0);
            wait_for_valid(n);
            word_check("o_instr", o_instr, exp_instr);
            pc_check("o_instr_pc", o_instr_pc, exp_pc);
            class_check("o_instr_class", o_instr_class, r.cls);
            for (int s = 0; s < int'(r.stall); s++)
            begin
                @(negedge i_clk);
                bit_check("o_instr_valid", o_instr_valid, 1'b1);
                word_check("o_instr", o_instr, exp_instr);
                pc_check("o_instr_pc", o_instr_pc, exp_pc);
                class_check("o_instr_class", o_instr_class, r.cls);
                if (r.stall >= 8'd16 && s >= int'(r.stall) - 8)
                    bit_check("o_imem_req", o_imem_req, 1'b0);  // Buffer is full by now
            end
            i_instr_ready = 1'b1;
            @(negedge i_clk);
            exp_pc = exp_pc + pc_t'(r.len / 16);
        end
        i_instr_ready = 1'b0;
    endtask

    initial
    begin
        void'($urandom(48));
        i_reset_n     = 1'b0;
        i_start_pc    = '0;
        i_instr_ready = 1'b0;
        build_table();
        run_table(pc_t'(15'h0040));    // Aligned start
        run_table(pc_t'(15'h0101));    // Start in the upper half of a word
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tb/imem_model.sv ====
`timescale 1ns/1ps

`include "fetch_config.svh"

module imem_model
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic                        i_req,
    input  logic [`FETCH_PC_BITS-3:0]   i_addr,
    output fetch_pkg::word_t            o_rdata,
    output logic                        o_valid
);

    import fetch_pkg::*;

    localparam int MemHalves = 1 << (`FETCH_PC_BITS - 1);

    half_t                      mem [MemHalves];   // Loaded by the testbench
    logic                       pending;
    int unsigned                delay;
    logic [`FETCH_PC_BITS-3:0]  addr;

    initial
    begin
        o_rdata = '0;
        o_valid = 1'b0;
        pending = 1'b0;
        delay   = 0;
        addr    = '0;
    end

    // Responses change on the falling edge, the DUT samples them on the rising one
    always @(negedge i_clk)
    begin
        if (!i_reset_n)
        begin
            pending <= 1'b0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= 1'b0;
            if (pending)
            begin
                if (delay == 0)
                begin
                    o_rdata <= {mem[{addr, 1'b1}], mem[{addr, 1'b0}]};
                    o_valid <= 1'b1;
                    pending <= 1'b0;
                end
                else
                    delay <= delay - 1;
            end
            else if (i_req)
            begin
                pending <= 1'b1;
                addr    <= i_addr;
                delay   <= $urandom % 4;    // Zero to three extra cycles
            end
        end
    end

endmodule
